/* design/lsq_pkg.sv */
package lsq_pkg;

    // queue geometry and datapath width
    localparam int LSQ_DEPTH = 8;
    localparam int XLEN      = 32;

    typedef logic [4:0]      rob_tag_t;
    typedef logic [2:0]      lsq_idx_t;
    typedef logic [6:0]      preg_t;
    typedef logic [XLEN-1:0] word_t;

    // memory operation kind
    typedef logic [1:0] mem_op_t;

    localparam mem_op_t OP_LW  = 2'd0;
    localparam mem_op_t OP_LBU = 2'd1;
    localparam mem_op_t OP_SW  = 2'd2;
    localparam mem_op_t OP_SH  = 2'd3;

    // stores occupy the upper half of the encoding
    function automatic logic is_store(mem_op_t op);
        return op[1];
    endfunction

    typedef struct packed {
        rob_tag_t rob_tag;
        mem_op_t  op;
        word_t    base;
        word_t    imm;
        word_t    data;
        preg_t    pd;
    } issue_op_t;

    typedef struct packed {
        rob_tag_t rob_tag;
        mem_op_t  op;
        word_t    addr;
        word_t    data;
        preg_t    pd;
    } agen_op_t;

    // ready means the address has been captured
    typedef struct packed {
        logic     valid;
        logic     ready;
        logic     resolved;
        rob_tag_t rob_tag;
        mem_op_t  op;
        word_t    addr;
        word_t    data;
        preg_t    pd;
    } lsq_entry_t;

    typedef struct packed {
        rob_tag_t rob_tag;
        preg_t    pd;
        word_t    data;
    } load_result_t;

    typedef struct packed {
        rob_tag_t rob_tag;
        preg_t    pd;
        mem_op_t  op;
        word_t    addr;
    } mem_req_t;

    typedef struct packed {
        mem_op_t op;
        word_t   addr;
        word_t   data;
    } store_wb_t;

endpackage

/* design/lsq_agen.sv */
`timescale 1ns/1ps

module lsq_agen import lsq_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  logic      issue_valid,
    input  issue_op_t issue_op,
    output logic      agen_valid,
    output agen_op_t  agen_op
);

    word_t eff_addr;

    // base plus immediate, kept in front of the register
    assign eff_addr = issue_op.base + issue_op.imm;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            agen_valid <= 1'b0;
        end else begin
            agen_valid <= issue_valid;
        end
    end

    // operation payload follows the strobe
    always_ff @(posedge clk) begin
        if (issue_valid) begin
            agen_op.rob_tag <= issue_op.rob_tag;
            agen_op.op      <= issue_op.op;
            agen_op.addr    <= eff_addr;
            agen_op.data    <= issue_op.data;
            agen_op.pd      <= issue_op.pd;
        end
    end

endmodule

/* design/lsq_queue.sv */
`timescale 1ns/1ps

module lsq_queue import lsq_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  logic       dispatch_valid,
    input  rob_tag_t   dispatch_tag,
    input  logic       agen_valid,
    input  agen_op_t   agen_op,
    input  logic       resolve_valid,
    input  lsq_idx_t   resolve_idx,
    input  logic       retire,
    input  rob_tag_t   rob_head,
    output lsq_entry_t entries [LSQ_DEPTH],
    output lsq_idx_t   head,
    output logic       full,
    output logic       store_done,
    output rob_tag_t   store_done_tag,
    output logic       store_wb_valid,
    output store_wb_t  store_wb
);

    // per-slot control flags
    logic [LSQ_DEPTH-1:0] valid_q;
    logic [LSQ_DEPTH-1:0] ready_q;
    logic [LSQ_DEPTH-1:0] resolved_q;

    // per-slot payload
    rob_tag_t tag_q  [LSQ_DEPTH];
    mem_op_t  op_q   [LSQ_DEPTH];
    word_t    addr_q [LSQ_DEPTH];
    word_t    data_q [LSQ_DEPTH];
    preg_t    pd_q   [LSQ_DEPTH];

    // ring pointers
    lsq_idx_t wr_ptr;
    lsq_idx_t rd_ptr;

    logic     do_alloc;
    logic     do_capture;
    logic     cap_hit;
    lsq_idx_t cap_idx;
    logic     head_is_store;
    logic     do_retire;

    assign full     = &valid_q;
    assign do_alloc = dispatch_valid && !full;
    assign head     = rd_ptr;

    // find the waiting slot that owns the incoming rob tag
    always_comb begin
        cap_hit = 1'b0;
        cap_idx = '0;
        for (int i = 0; i < LSQ_DEPTH; i++) begin
            if (valid_q[i] && !ready_q[i] && tag_q[i] == agen_op.rob_tag) begin
                cap_hit = 1'b1;
                cap_idx = lsq_idx_t'(i);
            end
        end
    end

    assign do_capture = agen_valid && cap_hit;

    // head leaves once the rob retires it
    // a load also has to be resolved first
    assign head_is_store = is_store(op_q[rd_ptr]);
    assign do_retire = retire
                    && valid_q[rd_ptr]
                    && ready_q[rd_ptr]
                    && tag_q[rd_ptr] == rob_head
                    && (head_is_store || resolved_q[rd_ptr]);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            valid_q        <= '0;
            ready_q        <= '0;
            resolved_q     <= '0;
            wr_ptr         <= '0;
            rd_ptr         <= '0;
            store_done     <= 1'b0;
            store_wb_valid <= 1'b0;
        end else begin
            store_done     <= do_capture && is_store(agen_op.op);
            store_wb_valid <= do_retire && head_is_store;

            if (do_alloc) begin
                valid_q[wr_ptr]    <= 1'b1;
                ready_q[wr_ptr]    <= 1'b0;
                resolved_q[wr_ptr] <= 1'b0;
                wr_ptr             <= wr_ptr + 1'b1;
            end

            if (do_capture) begin
                ready_q[cap_idx] <= 1'b1;
            end

            // forward stage has taken this load
            if (resolve_valid) begin
                resolved_q[resolve_idx] <= 1'b1;
            end

            if (do_retire) begin
                valid_q[rd_ptr]    <= 1'b0;
                ready_q[rd_ptr]    <= 1'b0;
                resolved_q[rd_ptr] <= 1'b0;
                rd_ptr             <= rd_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (do_alloc) begin
            tag_q[wr_ptr] <= dispatch_tag;
        end

        if (do_capture) begin
            op_q[cap_idx]   <= agen_op.op;
            addr_q[cap_idx] <= agen_op.addr;
            data_q[cap_idx] <= agen_op.data;
            pd_q[cap_idx]   <= agen_op.pd;
            store_done_tag  <= agen_op.rob_tag;
        end

        // write-back payload of the retiring store
        if (do_retire) begin
            store_wb.op   <= op_q[rd_ptr];
            store_wb.addr <= addr_q[rd_ptr];
            store_wb.data <= data_q[rd_ptr];
        end
    end

    // present the ring to the forward stage
    always_comb begin
        for (int i = 0; i < LSQ_DEPTH; i++) begin
            entries[i].valid    = valid_q[i];
            entries[i].ready    = ready_q[i];
            entries[i].resolved = resolved_q[i];
            entries[i].rob_tag  = tag_q[i];
            entries[i].op       = op_q[i];
            entries[i].addr     = addr_q[i];
            entries[i].data     = data_q[i];
            entries[i].pd       = pd_q[i];
        end
    end

endmodule

/* design/lsq_forward.sv */
`timescale 1ns/1ps

module lsq_forward import lsq_pkg::*; (
    input  logic         clk,
    input  logic         reset,
    input  lsq_entry_t   entries [LSQ_DEPTH],
    input  lsq_idx_t     head,
    output logic         resolve_valid,
    output lsq_idx_t     resolve_idx,
    output logic         fwd_valid,
    output load_result_t fwd_result,
    output logic         mem_req_valid,
    output mem_req_t     mem_req
);

    // bytes touched by each access
    function automatic logic [2:0] byte_len(mem_op_t op);
        case (op)
            OP_LW:   return 3'd4;
            OP_SW:   return 3'd4;
            OP_SH:   return 3'd2;
            OP_LBU:  return 3'd1;
            default: return 3'd1;
        endcase
    endfunction

    // range intersection, one extra bit so the end never wraps
    function automatic logic overlaps(lsq_entry_t st, lsq_entry_t ld);
        logic [XLEN:0] st_lo;
        logic [XLEN:0] st_hi;
        logic [XLEN:0] ld_lo;
        logic [XLEN:0] ld_hi;
        st_lo = {1'b0, st.addr};
        ld_lo = {1'b0, ld.addr};
        st_hi = st_lo + byte_len(st.op);
        ld_hi = ld_lo + byte_len(ld.op);
        return (ld_lo < st_hi) && (st_lo < ld_hi);
    endfunction

    logic       sel_found;
    lsq_idx_t   sel_idx;
    lsq_idx_t   sel_age;
    logic       addr_stall;
    lsq_entry_t ld;
    logic       hit;
    lsq_entry_t hit_st;
    logic [1:0] byte_off;
    word_t      shifted;
    logic       fwd_word;
    logic       fwd_byte;
    logic       partial;
    word_t      fwd_data;

    // oldest ready, unresolved load, walking from head
    always_comb begin
        lsq_idx_t idx;
        logic     unready_seen;
        sel_found    = 1'b0;
        sel_idx      = head;
        sel_age      = '0;
        addr_stall   = 1'b0;
        unready_seen = 1'b0;
        for (int k = 0; k < LSQ_DEPTH; k++) begin
            idx = head + lsq_idx_t'(k);
            if (!sel_found && entries[idx].valid) begin
                if (!entries[idx].ready) begin
                    unready_seen = 1'b1;
                end else if (!is_store(entries[idx].op) && !entries[idx].resolved) begin
                    sel_found  = 1'b1;
                    sel_idx    = idx;
                    sel_age    = lsq_idx_t'(k);
                    addr_stall = unready_seen;
                end
            end
        end
    end

    assign ld = entries[sel_idx];

    // later matches overwrite, so the youngest older store wins
    always_comb begin
        lsq_idx_t   idx;
        lsq_entry_t st;
        hit    = 1'b0;
        hit_st = '0;
        for (int k = 0; k < LSQ_DEPTH; k++) begin
            idx = head + lsq_idx_t'(k);
            st  = entries[idx];
            if (k < sel_age && st.valid && st.ready && is_store(st.op) && overlaps(st, ld)) begin
                hit    = 1'b1;
                hit_st = st;
            end
        end
    end

    assign byte_off = ld.addr[1:0] - hit_st.addr[1:0];
    assign shifted  = hit_st.data >> {byte_off, 3'b000};

    assign fwd_word = hit && hit_st.op == OP_SW && ld.op == OP_LW && ld.addr == hit_st.addr;
    assign fwd_byte = hit && ld.op == OP_LBU;
    // anything else waits for the store to drain
    assign partial  = hit && !fwd_word && !fwd_byte;

    assign fwd_data = fwd_word ? hit_st.data : word_t'(shifted[7:0]);

    assign resolve_valid = sel_found && !addr_stall && !partial;
    assign resolve_idx   = sel_idx;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            fwd_valid     <= 1'b0;
            mem_req_valid <= 1'b0;
        end else begin
            fwd_valid     <= resolve_valid && hit;
            mem_req_valid <= resolve_valid && !hit;
        end
    end

    always_ff @(posedge clk) begin
        if (resolve_valid) begin
            fwd_result.rob_tag <= ld.rob_tag;
            fwd_result.pd      <= ld.pd;
            fwd_result.data    <= fwd_data;
            mem_req.rob_tag    <= ld.rob_tag;
            mem_req.pd         <= ld.pd;
            mem_req.op         <= ld.op;
            mem_req.addr       <= ld.addr;
        end
    end

endmodule

/* design/lsq_top.sv */
`timescale 1ns/1ps

module lsq_top import lsq_pkg::*; (
    input  logic         clk,
    input  logic         reset,
    input  logic         dispatch_valid,
    input  rob_tag_t     dispatch_tag,
    input  logic         issue_valid,
    input  issue_op_t    issue_op,
    input  logic         retire,
    input  rob_tag_t     rob_head,
    output logic         full,
    output logic         store_done,
    output rob_tag_t     store_done_tag,
    output logic         fwd_valid,
    output load_result_t fwd_result,
    output logic         mem_req_valid,
    output mem_req_t     mem_req,
    output logic         store_wb_valid,
    output store_wb_t    store_wb
);

    // agen to queue
    logic       agen_valid;
    agen_op_t   agen_op;

    // queue to forward and back
    lsq_entry_t entries [LSQ_DEPTH];
    lsq_idx_t   head;
    logic       resolve_valid;
    lsq_idx_t   resolve_idx;

    lsq_agen u_agen (
        .clk         (clk),
        .reset       (reset),
        .issue_valid (issue_valid),
        .issue_op    (issue_op),
        .agen_valid  (agen_valid),
        .agen_op     (agen_op)
    );

    lsq_queue u_queue (
        .clk            (clk),
        .reset          (reset),
        .dispatch_valid (dispatch_valid),
        .dispatch_tag   (dispatch_tag),
        .agen_valid     (agen_valid),
        .agen_op        (agen_op),
        .resolve_valid  (resolve_valid),
        .resolve_idx    (resolve_idx),
        .retire         (retire),
        .rob_head       (rob_head),
        .entries        (entries),
        .head           (head),
        .full           (full),
        .store_done     (store_done),
        .store_done_tag (store_done_tag),
        .store_wb_valid (store_wb_valid),
        .store_wb       (store_wb)
    );

    lsq_forward u_forward (
        .clk           (clk),
        .reset         (reset),
        .entries       (entries),
        .head          (head),
        .resolve_valid (resolve_valid),
        .resolve_idx   (resolve_idx),
        .fwd_valid     (fwd_valid),
        .fwd_result    (fwd_result),
        .mem_req_valid (mem_req_valid),
        .mem_req       (mem_req)
    );

endmodule

/* verif/lsq_checker.sv */
`timescale 1ns/1ps

module lsq_checker import lsq_pkg::*; (
    input logic clk,
    input logic reset,
    input logic issue_valid,
    input logic retire,
    input logic store_done,
    input logic fwd_valid,
    input logic mem_req_valid,
    input logic store_wb_valid
);

    // a load takes exactly one path
    a_one_path: assert property (@(posedge clk) disable iff (reset)
        !(fwd_valid && mem_req_valid))
        else $error("fwd_valid and mem_req_valid high together");

    a_wb_after_retire: assert property (@(posedge clk) disable iff (reset)
        store_wb_valid |-> $past(retire))
        else $error("store_wb_valid without retire one cycle before");

    // agen register, then queue capture
    a_done_after_issue: assert property (@(posedge clk) disable iff (reset)
        store_done |-> $past(issue_valid, 2))
        else $error("store_done without issue two cycles before");

    a_quiet_in_reset: assert property (@(posedge clk)
        reset |-> !(store_done || fwd_valid || mem_req_valid || store_wb_valid))
        else $error("output pulse while reset is high");

endmodule

bind lsq_top lsq_checker u_checker (.*);

/* verif/lsq_tb.sv */
`timescale 1ns/1ps

module lsq_tb import lsq_pkg::*; ();

    localparam int LIMIT = 2 * (8 * 60 + 40 * 40);

    typedef struct {
        rob_tag_t tag;
        mem_op_t  op;
        word_t    base;
        word_t    imm;
        word_t    addr;
        word_t    data;
        preg_t    pd;
        bit       iss;
        bit       res;
    } model_t;

    // kind 0 stall, 1 forward, 2 memory
    typedef struct {
        int    kind;
        word_t data;
    } exp_t;

    logic clk, reset, dispatch_valid, issue_valid, retire;
    rob_tag_t dispatch_tag, rob_head, store_done_tag;
    issue_op_t issue_op;
    logic full, store_done, fwd_valid, mem_req_valid, store_wb_valid;
    load_result_t fwd_result;
    mem_req_t mem_req;
    store_wb_t store_wb;

    model_t mq[$];
    rob_tag_t exp_done[$];
    store_wb_t exp_wb[$];
    rob_tag_t next_tag;
    int cycles;

    lsq_top DUT (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic fail_msg(string what);
        $display("%s at %0t", what, $time);
        $display("Checks failed");
        $fatal(1);
    endtask

    task automatic check_tag(string name, rob_tag_t exp, rob_tag_t act);
        if (exp !== act) begin
            $display("ERR %0t %s exp=%h act=%h", $time, name, exp, act);
            fail_msg("tag mismatch");
        end
    endtask

    task automatic check_result(string name, load_result_t exp, load_result_t act);
        if (exp !== act) begin
            $display("ERR %0t %s exp=%h act=%h", $time, name, exp, act);
            fail_msg("forward result mismatch");
        end
    endtask

    task automatic check_mem_req(string name, mem_req_t exp, mem_req_t act);
        if (exp !== act) begin
            $display("ERR %0t %s exp=%h act=%h", $time, name, exp, act);
            fail_msg("memory request mismatch");
        end
    endtask

    task automatic check_wb(string name, store_wb_t exp, store_wb_t act);
        if (exp !== act) begin
            $display("ERR %0t %s exp=%h act=%h", $time, name, exp, act);
            fail_msg("store write-back mismatch");
        end
    endtask

    function automatic bit is_st(mem_op_t op);
        return op == OP_SW || op == OP_SH;
    endfunction

    // expected outcome of the load at model index j
    function automatic exp_t ref_load(int j);
        exp_t e;
        longint la;
        longint sa;
        longint sl;
        longint ll;
        e.kind = 2;
        e.data = '0;
        la = mq[j].addr;
        ll = (mq[j].op == OP_LW) ? 4 : 1;
        for (int k = 0; k < j; k++) begin
            if (!mq[k].iss) e.kind = 0;
        end
        if (e.kind == 0) return e;
        // youngest older store first
        for (int k = j - 1; k >= 0; k--) begin
            sa = mq[k].addr;
            sl = (mq[k].op == OP_SW) ? 4 : 2;
            if (is_st(mq[k].op) && la < sa + sl && sa < la + ll) begin
                if (mq[k].op == OP_SW && mq[j].op == OP_LW && la == sa) begin
                    e.kind = 1;
                    e.data = mq[k].data;
                end else if (mq[j].op == OP_LBU) begin
                    e.kind = 1;
                    e.data = (mq[k].data >> (8 * (la - sa))) & 32'hff;
                end else begin
                    e.kind = 0;
                end
                return e;
            end
        end
        return e;
    endfunction

    // oldest pending load can resolve with the current model state
    function automatic bit load_due();
        exp_t e;
        foreach (mq[i]) begin
            if (!is_st(mq[i].op) && mq[i].iss && !mq[i].res) begin
                e = ref_load(i);
                return e.kind != 0;
            end
        end
        return 1'b0;
    endfunction

    task automatic add_op(mem_op_t op, word_t base, word_t imm, word_t data);
        model_t m;
        @(negedge clk);
        dispatch_valid = 1'b1;
        dispatch_tag = next_tag;
        if (!full) begin
            m = '{next_tag, op, base, imm, '0, data, preg_t'($urandom), 0, 0};
            mq.push_back(m);
        end
        next_tag++;
        @(negedge clk);
        dispatch_valid = 1'b0;
    endtask

    task automatic issue(int i);
        @(negedge clk);
        issue_valid = 1'b1;
        issue_op = '{mq[i].tag, mq[i].op, mq[i].base, mq[i].imm, mq[i].data, mq[i].pd};
        mq[i].addr = mq[i].base + mq[i].imm;
        mq[i].iss = 1'b1;
        if (is_st(mq[i].op)) exp_done.push_back(mq[i].tag);
        @(negedge clk);
        issue_valid = 1'b0;
        repeat (3) @(negedge clk);
    endtask

    // a store leaves only once no load result is still on its way
    task automatic retire_head();
        while (load_due() || !(is_st(mq[0].op) || mq[0].res)) @(negedge clk);
        retire = 1'b1;
        rob_head = mq[0].tag;
        if (is_st(mq[0].op)) exp_wb.push_back('{mq[0].op, mq[0].addr, mq[0].data});
        void'(mq.pop_front());
        @(negedge clk);
        retire = 1'b0;
    endtask

    task automatic run_all();
        foreach (mq[i]) issue(i);
        while (mq.size() > 0) retire_head();
    endtask

    // sampled one ns after the edge, where outputs are settled
    always begin
        int j;
        exp_t e;
        @(posedge clk);
        #1;
        if (!reset && store_done) begin
            if (exp_done.size() == 0) fail_msg("unexpected store_done");
            check_tag("store_done_tag", exp_done.pop_front(), store_done_tag);
        end
        if (!reset && store_wb_valid) begin
            if (exp_wb.size() == 0) fail_msg("unexpected store_wb_valid");
            check_wb("store_wb", exp_wb.pop_front(), store_wb);
        end
        if (!reset && (fwd_valid || mem_req_valid)) begin
            j = -1;
            foreach (mq[i]) begin
                if (j < 0 && !is_st(mq[i].op) && mq[i].iss && !mq[i].res) j = i;
            end
            if (j < 0) fail_msg("load result with no pending load");
            e = ref_load(j);
            if (e.kind == 0) fail_msg("load resolved while it should stall");
            if (fwd_valid != (e.kind == 1)) fail_msg("load took the wrong path");
            if (fwd_valid) check_result("fwd_result", '{mq[j].tag, mq[j].pd, e.data}, fwd_result);
            else check_mem_req("mem_req", '{mq[j].tag, mq[j].pd, mq[j].op, mq[j].addr}, mem_req);
            mq[j].res = 1'b1;
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > LIMIT) fail_msg("timeout, run exceeded its cycle limit");
    end

    initial begin
        int off;
        word_t base;
        mem_op_t op;
        void'($urandom(69994));
        {dispatch_valid, issue_valid, retire} = '0;
        {dispatch_tag, rob_head, issue_op} = '0;
        next_tag = '0;
        cycles = 0;
        reset = 1'b1;
        repeat (3) @(negedge clk);
        reset = 1'b0;
        if (full || store_done || fwd_valid || mem_req_valid || store_wb_valid)
            fail_msg("outputs not low after reset");
        // fill, ninth dispatch dropped, one retire frees a slot
        for (int i = 0; i < 9; i++) add_op(OP_SW, 32'h1000, 32'(i * 4), $urandom);
        if (!full || mq.size() != 8) fail_msg("queue not full after eight dispatches");
        foreach (mq[i]) issue(i);
        retire_head();
        @(negedge clk);
        if (full) fail_msg("full still high after retire");
        while (mq.size() > 0) retire_head();
        // word forward, then byte forwards with youngest store winning
        add_op(OP_SW, 32'h2000, 32'h10, 32'hcafe_f00d);
        add_op(OP_LW, 32'h2010, 32'h0, 0);
        run_all();
        add_op(OP_SW, 32'h3000, 32'h0, 32'h1122_3344);
        add_op(OP_SH, 32'h3000, 32'h2, 32'h0000_abcd);
        add_op(OP_LBU, 32'h3001, 32'h2, 0);
        add_op(OP_LBU, 32'h3000, 32'h1, 0);
        run_all();
        // no overlap goes to memory
        add_op(OP_LW, 32'h5000, 32'h24, 0);
        add_op(OP_SW, 32'h6000, 32'h0, 32'h55);
        add_op(OP_LW, 32'h5020, 32'h4, 0);
        run_all();
        // load waits for the older store address
        add_op(OP_SW, 32'h7000, 32'h0, 32'h7777_0001);
        add_op(OP_LW, 32'h7000, 32'h0, 0);
        issue(1);
        repeat (6) @(negedge clk);
        issue(0);
        while (mq.size() > 0) retire_head();
        // partial overlap holds until the sh retires
        add_op(OP_SH, 32'h7100, 32'h0, 32'h1234);
        add_op(OP_LW, 32'h7100, 32'h0, 0);
        issue(0);
        issue(1);
        repeat (6) @(negedge clk);
        while (mq.size() > 0) retire_head();
        for (int r = 0; r < 40; r++) begin
            for (int i = 0; i < 4; i++) begin
                op = mem_op_t'($urandom % 4);
                off = $urandom % 16;
                if (op == OP_LW || op == OP_SW) off = off & ~3;
                if (op == OP_SH) off = off & ~1;
                base = $urandom;
                add_op(op, base, 32'h4000 + off - base, $urandom);
            end
            for (int i = 0; i < 4; i++) issue((r % 2) ? 3 - i : i);
            while (mq.size() > 0) retire_head();
        end
        repeat (4) @(negedge clk);
        if (exp_done.size() != 0 || exp_wb.size() != 0) begin
            fail_msg("expected pulses never arrived");
        end else begin
            $display("All checks passed");
            $finish;
        end
    end

endmodule

/* compile.f */
design/lsq_pkg.sv
design/lsq_agen.sv
design/lsq_queue.sv
design/lsq_forward.sv
design/lsq_top.sv
verif/lsq_checker.sv
verif/lsq_tb.sv
